// ==== list.f ====
wavegen_pkg.sv
wavegen_ctrl.sv
wave_table.sv
amp_scaler.sv
wavegen_top.sv
wavegen_tb.sv

// ==== Makefile ====
TOP = wavegen_tb

.PHONY: compile run clean

compile: obj_dir/V$(TOP)

obj_dir/V$(TOP): list.f $(wildcard *.sv)
	verilator --binary --assert --timing -Wno-fatal --top-module $(TOP) -f list.f

# The run passes only when the log holds the pass message.
run: obj_dir/V$(TOP)
	./obj_dir/V$(TOP) | tee sim.log
	grep -q "^No errors$$" sim.log

clean:
	rm -rf obj_dir sim.log

// ==== wavegen_tb.sv ====
`timescale 1ns/1ps

module wavegen_tb;

	// One entry of the reference pipeline that was accepted in a run cycle.
	typedef struct packed {
		logic                                valid;
		logic [wavegen_pkg::PHASE_WIDTH-1:0] phase;
		wavegen_pkg::wave_shape_t            shape;
	} ref_entry_t;

	logic clk;
	logic rst;
	logic en_low_i;
	logic enh_conf_i;
	logic signed [wavegen_pkg::AMP_WIDTH-1:0] amp_i;
	wavegen_pkg::wave_shape_t sel_i;
	logic signed [wavegen_pkg::SAMPLE_WIDTH-1:0] data_o;
	logic wr_en_o;

	// Reference model state and its expected outputs.
	wavegen_pkg::gen_state_t m_state;
	logic [wavegen_pkg::PHASE_WIDTH-1:0] m_phase;
	logic signed [wavegen_pkg::AMP_WIDTH-1:0] m_amp;
	ref_entry_t m_stage;
	logic exp_wr;
	logic signed [wavegen_pkg::SAMPLE_WIDTH-1:0] exp_data;
	logic signed [wavegen_pkg::SAMPLE_WIDTH-1:0] exp_tol;
	logic signed [wavegen_pkg::SAMPLE_WIDTH-1:0] data_diff;

	int error_count = 0;
	int test_count = 0;
	int test_start = 0;
	int latency;

	wavegen_top wavegen_top_inst (
		.clk        (clk),
		.rst        (rst),
		.en_low_i   (en_low_i),
		.enh_conf_i (enh_conf_i),
		.amp_i      (amp_i),
		.sel_i      (sel_i),
		.data_o     (data_o),
		.wr_en_o    (wr_en_o)
	);

	always #20 clk = ~clk;

	task automatic report_mismatch(input string name, input int got, input int exp);
		$display("CHECK FAILED at %0t ns: %s got %0d expected %0d", $time, name, got, exp);
		error_count++;
	endtask

	// Rounds to the nearest integer with halves away from zero.
	function automatic int round_real(input real x);
		if (x >= 0.0) begin
			return $rtoi(x + 0.5);
		end
		return -$rtoi(0.5 - x);
	endfunction

	function automatic int sine_ref(input int p);
		real angle;
		angle = 2.0 * 3.141592653589793 * p / 256.0;
		return round_real(32767.0 * $sin(angle));
	endfunction

	// Unscaled sample of a shape at a given phase.
	function automatic int shape_ref(input wavegen_pkg::wave_shape_t shape, input int p);
		int k;
		k = (p < 128) ? p : 255 - p;
		case (shape)
			wavegen_pkg::SHAPE_SINE:     return sine_ref(p);
			wavegen_pkg::SHAPE_COSINE:   return sine_ref((p + 64) % 256);
			wavegen_pkg::SHAPE_TRIANGLE: return k * 512 - 32768;
			default:                     return (p < 128) ? 32767 : -32767;
		endcase
	endfunction

	// Only the low 16 bits of the product reach the output.
	function automatic logic signed [15:0] scale_ref(input int sample, input int amp);
		logic [31:0] prod;
		prod = sample * amp;
		return prod[15:0];
	endfunction

	// A configure request wins from every state. Without it the enable
	// alone picks between idle and generate.
	function automatic wavegen_pkg::gen_state_t next_state_ref(
		input wavegen_pkg::gen_state_t state, input logic conf, input logic en_low
	);
		if (conf) begin
			return wavegen_pkg::ST_CONFIG;
		end
		return en_low ? wavegen_pkg::ST_IDLE : wavegen_pkg::ST_GEN;
	endfunction

	// The model follows the timing rules. A run cycle enters the stage,
	// and the next cycle scales it by the amplitude held in that cycle.
	always @(posedge clk) begin
		if (rst) begin
			m_state  <= wavegen_pkg::ST_IDLE;
			m_phase  <= '0;
			m_amp    <= 4'sd1;
			m_stage  <= '0;
			exp_wr   <= 1'b0;
			exp_data <= '0;
			exp_tol  <= '0;
		end else begin
			m_state <= next_state_ref(m_state, enh_conf_i, en_low_i);
			m_phase <= (m_state == wavegen_pkg::ST_GEN) ? m_phase + 8'd1 : 8'd0;
			if (m_state == wavegen_pkg::ST_CONFIG) begin
				m_amp <= amp_i;
			end
			m_stage.valid <= (m_state == wavegen_pkg::ST_GEN);
			m_stage.phase <= m_phase;
			m_stage.shape <= sel_i;
			exp_wr   <= m_stage.valid;
			exp_data <= m_stage.valid ?
				scale_ref(shape_ref(m_stage.shape, int'(m_stage.phase)), int'(m_amp)) : '0;
			// Sine and cosine may be off by one before scaling.
			exp_tol  <= (m_stage.shape == wavegen_pkg::SHAPE_SINE ||
				m_stage.shape == wavegen_pkg::SHAPE_COSINE) ?
				((m_amp < 0) ? 16'(-m_amp) : 16'(m_amp)) : '0;
		end
	end

	assign data_diff = data_o - exp_data;

	// Outputs are compared at the falling edge, where they are stable.
	assert property (@(negedge clk) disable iff (rst) wr_en_o == exp_wr)
		else report_mismatch("wr_en_o", int'(wr_en_o), int'(exp_wr));
	assert property (@(negedge clk) disable iff (rst)
		!exp_wr || (data_diff <= exp_tol && data_diff >= -exp_tol))
		else report_mismatch("data_o", int'(data_o), int'(exp_data));
	assert property (@(negedge clk) disable iff (rst) exp_wr || data_o == '0)
		else report_mismatch("data_o", int'(data_o), 0);

	task automatic run_cycles(input int n);
		repeat (n) @(negedge clk);
	endtask

	task automatic run_random_sel(input int n);
		repeat (n) begin
			sel_i = wavegen_pkg::wave_shape_t'($urandom_range(3));
			@(negedge clk);
		end
	endtask

	// Counts falling edges until wr_en_o has the wanted level.
	task automatic wait_for_wr_en(input logic level, input int limit, output int cycles);
		cycles = 0;
		while (wr_en_o !== level && cycles < limit) begin
			@(negedge clk);
			cycles++;
		end
		if (wr_en_o !== level) begin
			$display("Timeout at %0t ns: wr_en_o did not go to %0b within %0d cycles",
				$time, level, limit);
			error_count++;
		end
	endtask

	task automatic end_test(input string name);
		test_count++;
		$display("Test %0d (%s) finished with %0d failed checks", test_count, name,
			error_count - test_start);
		test_start = error_count;
	endtask

	// Guards against a run that never ends.
	initial begin
		#200000;
		$display("Simulation limit reached before the tests completed");
		$display("Errors found");
		$finish;
	end

	initial begin
		void'($urandom(32'h3847));
		clk        = 1'b0;
		rst        = 1'b1;
		en_low_i   = 1'b1;
		enh_conf_i = 1'b0;
		amp_i      = '0;
		sel_i      = wavegen_pkg::SHAPE_SINE;
		run_cycles(2);
		rst = 1'b0;

		// Idle after reset must keep the output quiet.
		run_cycles(10);
		end_test("idle after reset");

		// More than a full sine period, which crosses the phase wrap.
		en_low_i = 1'b0;
		wait_for_wr_en(1'b1, 10, latency);
		run_cycles(300);
		end_test("sine at reset amplitude");

		run_random_sel(200);
		end_test("random shape select");

		// Several amplitudes are loaded and the last one, negative, stays.
		enh_conf_i = 1'b1;
		repeat (6) begin
			amp_i = 4'($urandom_range(15));
			@(negedge clk);
		end
		amp_i = -4'sd1 - 4'($urandom_range(7));
		@(negedge clk);
		enh_conf_i = 1'b0;
		wait_for_wr_en(1'b1, 10, latency);
		run_random_sel(120);
		end_test("amplitude configuration");

		// The strobe drops on the third falling edge after the stop.
		en_low_i = 1'b1;
		wait_for_wr_en(1'b0, 10, latency);
		assert (latency == 3) else report_mismatch("stop latency", latency, 3);
		run_cycles(5);
		en_low_i = 1'b0;
		wait_for_wr_en(1'b1, 10, latency);
		assert (latency == 3) else report_mismatch("restart latency", latency, 3);
		run_random_sel(80);
		end_test("stop and restart");

		// Configure straight from generation while samples are in flight.
		enh_conf_i = 1'b1;
		amp_i = 4'sd2 + 4'($urandom_range(5));
		@(negedge clk);
		enh_conf_i = 1'b0;
		run_random_sel(60);
		en_low_i = 1'b1;
		run_cycles(6);
		end_test("configure during generation");

		$display("Tests run: %0d, failed checks: %0d", test_count, error_count);
		if (error_count == 0) begin
			$display("No errors");
		end else begin
			$display("Errors found");
		end
		$finish;
	end

endmodule

// ==== wavegen_top.sv ====
`timescale 1ns/1ps

module wavegen_top (
	input  logic                                        clk,
	input  logic                                        rst,
	input  logic                                        en_low_i,
	input  logic                                        enh_conf_i,
	input  logic signed [wavegen_pkg::AMP_WIDTH-1:0]    amp_i,
	input  wavegen_pkg::wave_shape_t                    sel_i,
	output logic signed [wavegen_pkg::SAMPLE_WIDTH-1:0] data_o,
	output logic                                        wr_en_o
);

	// Control levels from the FSM to both datapath blocks.
	wavegen_pkg::gen_ctrl_t ctrl;

	// Registered sample between the table and the scaler.
	wavegen_pkg::wave_stage_t stage;

	// The FSM turns the configure and enable levels into controls.
	wavegen_ctrl wavegen_ctrl_inst (
		.clk        (clk),
		.rst        (rst),
		.enh_conf_i (enh_conf_i),
		.en_low_i   (en_low_i),
		.ctrl_o     (ctrl)
	);

	// The table produces one shaped sample per run cycle.
	// It is the first of the two pipeline stages.
	wave_table wave_table_inst (
		.clk     (clk),
		.rst     (rst),
		.ctrl_i  (ctrl),
		.sel_i   (sel_i),
		.stage_o (stage)
	);

	// The scaler applies the amplitude and drives the output strobe.
	// It is the second pipeline stage.
	amp_scaler amp_scaler_inst (
		.clk     (clk),
		.rst     (rst),
		.ctrl_i  (ctrl),
		.amp_i   (amp_i),
		.stage_i (stage),
		.data_o  (data_o),
		.wr_en_o (wr_en_o)
	);

endmodule

// ==== amp_scaler.sv ====
`timescale 1ns/1ps

module amp_scaler (
	input  logic                                        clk,
	input  logic                                        rst,
	input  wavegen_pkg::gen_ctrl_t                      ctrl_i,
	input  logic signed [wavegen_pkg::AMP_WIDTH-1:0]    amp_i,
	input  wavegen_pkg::wave_stage_t                    stage_i,
	output logic signed [wavegen_pkg::SAMPLE_WIDTH-1:0] data_o,
	output logic                                        wr_en_o
);

	// Amplitude in fixed point with the integer part above the fraction bits.
	logic signed [wavegen_pkg::AMP_WIDTH+wavegen_pkg::AMP_FRAC_BITS-1:0] amp_q;

	// Full product of sample and fixed-point amplitude.
	logic signed [wavegen_pkg::SAMPLE_WIDTH+wavegen_pkg::AMP_WIDTH+
		wavegen_pkg::AMP_FRAC_BITS-1:0] product;

	// Product with the fraction dropped and truncated to the sample width.
	logic signed [wavegen_pkg::SAMPLE_WIDTH-1:0] scaled;

	// Both operands are signed, so a negative amplitude inverts the wave.
	assign product = $signed(stage_i.sample) * amp_q;

	// The fraction bits of the amplitude are always zero, so these bits
	// are exactly the low bits of sample times amplitude.
	assign scaled = $signed(product[wavegen_pkg::AMP_FRAC_BITS +: wavegen_pkg::SAMPLE_WIDTH]);

	// The amplitude loads on every configure cycle and is used from the
	// next cycle on. The output register keeps data at zero between strobes.
	always_ff @(posedge clk) begin
		if (rst) begin
			amp_q   <= {wavegen_pkg::RESET_AMP, {wavegen_pkg::AMP_FRAC_BITS{1'b0}}};
			data_o  <= '0;
			wr_en_o <= 1'b0;
		end else begin
			if (ctrl_i.load_amp) begin
				amp_q <= {amp_i, {wavegen_pkg::AMP_FRAC_BITS{1'b0}}};
			end
			wr_en_o <= stage_i.valid;
			data_o  <= stage_i.valid ? scaled : '0;
		end
	end

endmodule

// ==== wave_table.sv ====
`timescale 1ns/1ps

module wave_table (
	input  logic                     clk,
	input  logic                     rst,
	input  wavegen_pkg::gen_ctrl_t   ctrl_i,
	input  wavegen_pkg::wave_shape_t sel_i,
	output wavegen_pkg::wave_stage_t stage_o
);

	// Phase counter that steps once per generated sample.
	logic [wavegen_pkg::PHASE_WIDTH-1:0] phase_q;

	// Phase of the cosine that leads the sine by a quarter period.
	logic [wavegen_pkg::PHASE_WIDTH-1:0] cos_phase;

	// Candidate samples for the current phase.
	logic signed [wavegen_pkg::SAMPLE_WIDTH-1:0] sine_val;
	logic signed [wavegen_pkg::SAMPLE_WIDTH-1:0] cosine_val;
	logic signed [wavegen_pkg::SAMPLE_WIDTH-1:0] triangle_val;
	logic signed [wavegen_pkg::SAMPLE_WIDTH-1:0] square_val;
	logic signed [wavegen_pkg::SAMPLE_WIDTH-1:0] shape_val;

	// Slope index of the triangle that rises in the first half period.
	logic [wavegen_pkg::PHASE_WIDTH-2:0] tri_k;

	// Stage register toward the scaler.
	wavegen_pkg::wave_stage_t stage_q;

	// The table holds the first quadrant of the sine as rounded
	// 32767 * sin(2*pi*idx/256).
	// The magnitude never reaches full scale here, so 15 bits hold it.
	function automatic logic [wavegen_pkg::SAMPLE_WIDTH-2:0] quarter_sine(
		input logic [$clog2(wavegen_pkg::QUARTER_DEPTH)-1:0] idx
	);
		case (idx)
			6'd0:  quarter_sine = 15'd0;
			6'd1:  quarter_sine = 15'd804;
			6'd2:  quarter_sine = 15'd1608;
			6'd3:  quarter_sine = 15'd2410;
			6'd4:  quarter_sine = 15'd3212;
			6'd5:  quarter_sine = 15'd4011;
			6'd6:  quarter_sine = 15'd4808;
			6'd7:  quarter_sine = 15'd5602;
			6'd8:  quarter_sine = 15'd6393;
			6'd9:  quarter_sine = 15'd7179;
			6'd10: quarter_sine = 15'd7962;
			6'd11: quarter_sine = 15'd8739;
			6'd12: quarter_sine = 15'd9512;
			6'd13: quarter_sine = 15'd10278;
			6'd14: quarter_sine = 15'd11039;
			6'd15: quarter_sine = 15'd11793;
			6'd16: quarter_sine = 15'd12539;
			6'd17: quarter_sine = 15'd13279;
			6'd18: quarter_sine = 15'd14010;
			6'd19: quarter_sine = 15'd14732;
			6'd20: quarter_sine = 15'd15446;
			6'd21: quarter_sine = 15'd16151;
			6'd22: quarter_sine = 15'd16846;
			6'd23: quarter_sine = 15'd17530;
			6'd24: quarter_sine = 15'd18204;
			6'd25: quarter_sine = 15'd18868;
			6'd26: quarter_sine = 15'd19519;
			6'd27: quarter_sine = 15'd20159;
			6'd28: quarter_sine = 15'd20787;
			6'd29: quarter_sine = 15'd21403;
			6'd30: quarter_sine = 15'd22005;
			6'd31: quarter_sine = 15'd22594;
			6'd32: quarter_sine = 15'd23170;
			6'd33: quarter_sine = 15'd23731;
			6'd34: quarter_sine = 15'd24279;
			6'd35: quarter_sine = 15'd24811;
			6'd36: quarter_sine = 15'd25329;
			6'd37: quarter_sine = 15'd25832;
			6'd38: quarter_sine = 15'd26319;
			6'd39: quarter_sine = 15'd26790;
			6'd40: quarter_sine = 15'd27245;
			6'd41: quarter_sine = 15'd27683;
			6'd42: quarter_sine = 15'd28105;
			6'd43: quarter_sine = 15'd28510;
			6'd44: quarter_sine = 15'd28898;
			6'd45: quarter_sine = 15'd29268;
			6'd46: quarter_sine = 15'd29621;
			6'd47: quarter_sine = 15'd29956;
			6'd48: quarter_sine = 15'd30273;
			6'd49: quarter_sine = 15'd30571;
			6'd50: quarter_sine = 15'd30852;
			6'd51: quarter_sine = 15'd31113;
			6'd52: quarter_sine = 15'd31356;
			6'd53: quarter_sine = 15'd31580;
			6'd54: quarter_sine = 15'd31785;
			6'd55: quarter_sine = 15'd31971;
			6'd56: quarter_sine = 15'd32137;
			6'd57: quarter_sine = 15'd32285;
			6'd58: quarter_sine = 15'd32412;
			6'd59: quarter_sine = 15'd32521;
			6'd60: quarter_sine = 15'd32609;
			6'd61: quarter_sine = 15'd32678;
			6'd62: quarter_sine = 15'd32728;
			6'd63: quarter_sine = 15'd32757;
			default: quarter_sine = 15'd0;
		endcase
	endfunction

	// Full-period sine from the quarter table.
	// The second quadrant reads the table mirrored, where index 64 - q is
	// the two's complement of q; q = 0 there is the peak, which is not
	// stored. The second half period is the first one negated.
	function automatic logic signed [wavegen_pkg::SAMPLE_WIDTH-1:0] sine_at(
		input logic [wavegen_pkg::PHASE_WIDTH-1:0] p
	);
		logic [$clog2(wavegen_pkg::QUARTER_DEPTH)-1:0] q;
		logic [wavegen_pkg::SAMPLE_WIDTH-2:0] mag;
		logic signed [wavegen_pkg::SAMPLE_WIDTH-1:0] pos;
		q = p[$clog2(wavegen_pkg::QUARTER_DEPTH)-1:0];
		if (!p[wavegen_pkg::PHASE_WIDTH-2]) begin
			mag = quarter_sine(q);
		end else if (q == '0) begin
			mag = wavegen_pkg::SAMPLE_MAX[wavegen_pkg::SAMPLE_WIDTH-2:0];
		end else begin
			mag = quarter_sine(-q);
		end
		pos = {1'b0, mag};
		sine_at = p[wavegen_pkg::PHASE_WIDTH-1] ? -pos : pos;
	endfunction

	// The phase is held at zero while cleared and advances once per run
	// cycle. It wraps from 255 to 0 on its own.
	always_ff @(posedge clk) begin
		if (rst) begin
			phase_q <= '0;
		end else if (ctrl_i.clear_phase) begin
			phase_q <= '0;
		end else if (ctrl_i.run) begin
			phase_q <= phase_q + 1'b1;
		end
	end

	// Cosine is the sine one quadrant later, so only the quadrant bits move.
	assign cos_phase = {phase_q[wavegen_pkg::PHASE_WIDTH-1 -: 2] + 2'd1,
		phase_q[wavegen_pkg::PHASE_WIDTH-3:0]};

	assign sine_val   = sine_at(phase_q);
	assign cosine_val = sine_at(cos_phase);

	// Triangle rises from -32768 in steps of 512 and falls back again.
	// For the falling half, 255 - p is the inverted low bits of p.
	assign tri_k = phase_q[wavegen_pkg::PHASE_WIDTH-1] ?
		~phase_q[wavegen_pkg::PHASE_WIDTH-2:0] :
		phase_q[wavegen_pkg::PHASE_WIDTH-2:0];
	assign triangle_val = $signed({tri_k, 9'd0} - 16'd32768);

	// square wave at full scale with the sign of the half period
	assign square_val = phase_q[wavegen_pkg::PHASE_WIDTH-1] ?
		-wavegen_pkg::SAMPLE_MAX : wavegen_pkg::SAMPLE_MAX;

	// The shape is selected fresh for every sample.
	always_comb begin
		case (sel_i)
			wavegen_pkg::SHAPE_SINE:     shape_val = sine_val;
			wavegen_pkg::SHAPE_COSINE:   shape_val = cosine_val;
			wavegen_pkg::SHAPE_TRIANGLE: shape_val = triangle_val;
			wavegen_pkg::SHAPE_SQUARE:   shape_val = square_val;
			default:                     shape_val = sine_val;
		endcase
	end

	// The stage register loads every cycle. Valid marks the cycles in
	// which the phase was advancing, one cycle after run.
	always_ff @(posedge clk) begin
		stage_q.sample <= shape_val;
		if (rst) begin
			stage_q.valid <= 1'b0;
		end else begin
			stage_q.valid <= ctrl_i.run;
		end
	end

	assign stage_o = stage_q;

endmodule

// ==== wavegen_ctrl.sv ====
`timescale 1ns/1ps

module wavegen_ctrl (
	input  logic                   clk,
	input  logic                   rst,
	input  logic                   enh_conf_i,
	input  logic                   en_low_i,
	output wavegen_pkg::gen_ctrl_t ctrl_o
);

	// Current and next state of the controller.
	wavegen_pkg::gen_state_t state_q;
	wavegen_pkg::gen_state_t state_d;

	// The state register starts in idle after reset.
	always_ff @(posedge clk) begin
		if (rst) begin
			state_q <= wavegen_pkg::ST_IDLE;
		end else begin
			state_q <= state_d;
		end
	end

	// Next-state logic.
	// The configure level always wins, so the amplitude can be changed
	// from any state, even in the middle of generation.
	// The enable is active low. With it low and no configure request the
	// generator runs, and with it high the generator goes back to idle.
	always_comb begin
		state_d = state_q;
		case (state_q)
			wavegen_pkg::ST_IDLE: begin
				// Idle leaves for configure first, otherwise for generate
				// once the enable is pulled low.
				if (enh_conf_i) begin
					state_d = wavegen_pkg::ST_CONFIG;
				end else if (!en_low_i) begin
					state_d = wavegen_pkg::ST_GEN;
				end else begin
					state_d = wavegen_pkg::ST_IDLE;
				end
			end
			wavegen_pkg::ST_CONFIG: begin
				// Configure holds as long as the request stays high.
				// On release the enable decides between generate and idle.
				if (enh_conf_i) begin
					state_d = wavegen_pkg::ST_CONFIG;
				end else if (!en_low_i) begin
					state_d = wavegen_pkg::ST_GEN;
				end else begin
					state_d = wavegen_pkg::ST_IDLE;
				end
			end
			wavegen_pkg::ST_GEN: begin
				// A configure request interrupts generation directly.
				if (enh_conf_i) begin
					state_d = wavegen_pkg::ST_CONFIG;
				end else if (en_low_i) begin
					state_d = wavegen_pkg::ST_IDLE;
				end else begin
					state_d = wavegen_pkg::ST_GEN;
				end
			end
			default: begin
				// The unused encoding falls back to idle.
				state_d = wavegen_pkg::ST_IDLE;
			end
		endcase
	end

	// The controls follow the registered state in the same cycle.
	// The phase is held at zero outside generation, so every run restarts
	// at the beginning of a period.
	always_comb begin
		ctrl_o.clear_phase = (state_q == wavegen_pkg::ST_IDLE) ||
			(state_q == wavegen_pkg::ST_CONFIG);
		ctrl_o.load_amp    = (state_q == wavegen_pkg::ST_CONFIG);
		ctrl_o.run         = (state_q == wavegen_pkg::ST_GEN);
	end

endmodule

// ==== wavegen_pkg.sv ====
package wavegen_pkg;

	// Width of one signed output sample.
	localparam int SAMPLE_WIDTH = 16;

	// Width of the phase counter, so one period spans 256 samples.
	localparam int PHASE_WIDTH = 8;

	// Number of entries in the quarter-wave sine table.
	localparam int QUARTER_DEPTH = 64;

	// Integer width of the signed amplitude input.
	localparam int AMP_WIDTH = 4;

	// Fraction bits placed below the amplitude inside the scaler register.
	localparam int AMP_FRAC_BITS = 12;

	// Positive full scale of a sample.
	localparam logic signed [SAMPLE_WIDTH-1:0] SAMPLE_MAX = 16'sd32767;

	// Amplitude after reset, which is a gain of one.
	localparam logic signed [AMP_WIDTH-1:0] RESET_AMP = 4'sd1;

	// Waveform shape chosen per sample by the select input.
	typedef enum logic [1:0] {
		SHAPE_SINE     = 2'd0,
		SHAPE_COSINE   = 2'd1,
		SHAPE_TRIANGLE = 2'd2,
		SHAPE_SQUARE   = 2'd3
	} wave_shape_t;

	// Controller states.
	typedef enum logic [1:0] {
		ST_IDLE   = 2'd0,
		ST_CONFIG = 2'd1,
		ST_GEN    = 2'd2
	} gen_state_t;

	// Control levels decoded from the controller state.
	typedef struct packed {
		logic clear_phase;
		logic load_amp;
		logic run;
	} gen_ctrl_t;

	// One registered sample on its way from the table to the scaler.
	typedef struct packed {
		logic                           valid;
		logic signed [SAMPLE_WIDTH-1:0] sample;
	} wave_stage_t;

endpackage
